// ==== include/arcade_config.svh ====
// shared constants for RTL and testbench; the colour widths must keep VGA a whole multiple of core
`ifndef ARCADE_CONFIG_SVH
`define ARCADE_CONFIG_SVH

`define KEY_CREDITS    2      // key events the receiver may have in flight
`define DAC_BITS       15     // sigma-delta accumulator width
`define CORE_COLOR_W   2
`define VGA_COLOR_W    6

`define CMD_BUTTONS    8'h01
`define CMD_JOY0       8'h02
`define CMD_KEY        8'h05
`define CMD_STATUS     8'h1e

`define KEY_EXT_PREFIX 8'he0  // ps/2 extended prefix
`define KEY_REL_PREFIX 8'hf0  // ps/2 break prefix

`define KEY_COIN       8'h2e
`define KEY_START1     8'h16
`define KEY_START2     8'h1e
`define KEY_FIRE_A     8'h14
`define KEY_FIRE_B     8'h11
`define KEY_UP         8'h75  // extended
`define KEY_DOWN       8'h72  // extended
`define KEY_LEFT       8'h6b  // extended
`define KEY_RIGHT      8'h74  // extended

`endif

// ==== hdl/arcade_cfg_pkg.sv ====
// status word as the board controller writes it; only bits 0 and 5:2 mean anything to this shell
package arcade_cfg_pkg;

	// one 32-bit word, loaded raw over spi and read by field in the shell
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [25:0] reserved;  // bits 31:6
			logic        blend;     // horizontal blend
			logic [1:0]  scanlines; // 0 off, 1 25%, 2 50%, 3 75%
			logic        rotate;    // sideways cabinet
			logic        spare;     // bit 1
			logic        core_reset;
		} f;
	} status_word_t;

endpackage

// ==== hdl/arcade_input_pkg.sv ====
// joystick byte as sent by the board controller; single player, two fire buttons only
package arcade_input_pkg;

	// raw byte from spi, decoded by field in the input mapper
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] spare;
			logic       fire_b;
			logic       fire_a;
			logic       up;
			logic       down;
			logic       left;
			logic       right;
		} f;
	} joy_word_t;

endpackage

// ==== hdl/user_io_spi.sv ====
// spi mode 0 msb first with sck below clk_sys/8; write only, no readback; one key byte per frame
`timescale 1ns/1ns
`include "arcade_config.svh"

module user_io_spi
	import arcade_cfg_pkg::*, arcade_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst,
	input  logic         spi_sck,
	input  logic         spi_di,
	input  logic         conf_data0,
	input  logic         key_credit,
	output status_word_t status,
	output logic [1:0]   buttons,
	output logic [1:0]   switches,
	output joy_word_t    joystick_0,
	output logic         key_strobe,
	output logic         key_pressed,
	output logic [8:0]   key_code,
	output logic         core_reset
);

localparam int CW = $clog2(`KEY_CREDITS + 1);

////////////////////////////////////////////////////////////////////////////
// line synchronizers and byte shifter

logic [2:0] sck_sync;   // bit 2 is the previous sample
logic [1:0] di_sync;
logic [1:0] ss_sync;
logic       sck_rise;
logic       ss_active;
logic [2:0] bit_cnt;
logic [6:0] shift_q;
logic [7:0] rx_byte;
logic       byte_done;

always_ff @(posedge clk_sys) begin
	sck_sync <= {sck_sync[1:0], spi_sck};
	di_sync  <= {di_sync[0], spi_di};
	ss_sync  <= {ss_sync[0], conf_data0};
end

assign sck_rise  = sck_sync[1] & ~sck_sync[2];
assign ss_active = ~ss_sync[1];             // select is active low
assign rx_byte   = {shift_q, di_sync[1]};   // di aligned with sck_sync[1]
assign byte_done = ss_active & sck_rise & (bit_cnt == 3'd7);

always_ff @(posedge clk_sys) begin
	if (rst || !ss_active) begin
		bit_cnt <= '0;                      // deselect drops a partial byte
	end else if (sck_rise) begin
		bit_cnt <= bit_cnt + 3'd1;
	end
end

always_ff @(posedge clk_sys) begin
	if (sck_rise) begin
		shift_q <= rx_byte[6:0];
	end
end

////////////////////////////////////////////////////////////////////////////
// command decode

logic [7:0]  cmd;
logic [2:0]  byte_cnt;    // 0 while the command byte shifts in
logic [23:0] status_sh;   // low three status bytes

always_ff @(posedge clk_sys) begin
	if (rst || !ss_active) begin
		byte_cnt <= '0;
	end else if (byte_done && byte_cnt != 3'd7) begin
		byte_cnt <= byte_cnt + 3'd1;        // saturates on long frames
	end
end

always_ff @(posedge clk_sys) begin
	if (byte_done) begin
		if (byte_cnt == 3'd0) begin
			cmd <= rx_byte;
		end else if (cmd == `CMD_STATUS) begin
			case (byte_cnt)
			3'd1: status_sh[7:0]   <= rx_byte;
			3'd2: status_sh[15:8]  <= rx_byte;
			3'd3: status_sh[23:16] <= rx_byte;
			default: ;
			endcase
		end
	end
end

always_ff @(posedge clk_sys) begin
	if (rst) begin
		status     <= '0;
		buttons    <= '0;
		switches   <= '0;
		joystick_0 <= '0;
	end else if (byte_done) begin
		case (cmd)
		`CMD_STATUS: begin
			if (byte_cnt == 3'd4) begin
				status.raw <= {rx_byte, status_sh};   // whole word at once
			end
		end
		`CMD_BUTTONS: begin
			if (byte_cnt == 3'd1) begin
				buttons  <= rx_byte[1:0];
				switches <= rx_byte[3:2];
			end
		end
		`CMD_JOY0: begin
			if (byte_cnt == 3'd1) begin
				joystick_0.raw <= rx_byte;
			end
		end
		default: ;
		endcase
	end
end

always_ff @(posedge clk_sys) begin
	core_reset <= rst | status.f.core_reset | buttons[1];
end

////////////////////////////////////////////////////////////////////////////
// ps/2 prefix folding and credit-limited key events

logic          key_byte;
logic          key_ext;
logic          key_rel;
logic          new_evt;
logic [8:0]    new_code;
logic [CW-1:0] key_credits;
logic          can_issue;
logic          issue_hold;
logic          hold_load;
logic          hold_valid;
logic [8:0]    hold_code;
logic          hold_pressed;

assign key_byte = byte_done & (byte_cnt == 3'd1) & (cmd == `CMD_KEY);
assign new_evt  = key_byte & (rx_byte != `KEY_EXT_PREFIX) & (rx_byte != `KEY_REL_PREFIX);
assign new_code = {key_ext, rx_byte};

// a strobe in flight has not yet been taken off the count
assign can_issue  = key_credits > CW'(key_strobe);
assign issue_hold = hold_valid & can_issue;
assign hold_load  = new_evt & (hold_valid ? can_issue : !can_issue);

always_ff @(posedge clk_sys) begin
	if (rst) begin
		key_ext <= 1'b0;
		key_rel <= 1'b0;
	end else if (key_byte) begin
		if (rx_byte == `KEY_EXT_PREFIX) begin
			key_ext <= 1'b1;
		end else if (rx_byte == `KEY_REL_PREFIX) begin
			key_rel <= 1'b1;
		end else begin
			key_ext <= 1'b0;                // flags end with the code byte
			key_rel <= 1'b0;
		end
	end
end

always_ff @(posedge clk_sys) begin
	if (rst) begin
		key_credits <= CW'(`KEY_CREDITS);
		key_strobe  <= 1'b0;
		hold_valid  <= 1'b0;
	end else begin
		key_credits <= key_credits - CW'(key_strobe) + CW'(key_credit);
		key_strobe  <= can_issue & (hold_valid | new_evt);
		if (issue_hold) begin
			hold_valid <= new_evt;          // refilled by a same-cycle code
		end else if (new_evt && !can_issue) begin
			hold_valid <= 1'b1;             // already full means dropped
		end
	end
end

always_ff @(posedge clk_sys) begin
	if (issue_hold) begin
		key_code    <= hold_code;
		key_pressed <= hold_pressed;
	end else if (new_evt) begin
		key_code    <= new_code;
		key_pressed <= ~key_rel;
	end
	if (hold_load) begin
		hold_code    <= new_code;
		hold_pressed <= ~key_rel;
	end
end

endmodule

// ==== hdl/arcade_inputs.sv ====
// player 1 only; keys are matched on {extended, scan code} and rotation is one fixed quarter turn
`timescale 1ns/1ns
`include "arcade_config.svh"

module arcade_inputs
	import arcade_cfg_pkg::*, arcade_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst,
	input  logic         key_strobe,
	input  logic         key_pressed,
	input  logic [8:0]   key_code,
	input  joy_word_t    joystick_0,
	input  status_word_t status,
	output logic         key_credit,
	output logic         btn_coin,
	output logic [1:0]   btn_start,
	output logic         btn_left,
	output logic         btn_right,
	output logic         btn_up,
	output logic         btn_down,
	output logic         btn_fire,
	output logic         btn_barrier
);

localparam logic [8:0] SC_COIN   = {1'b0, `KEY_COIN};
localparam logic [8:0] SC_START1 = {1'b0, `KEY_START1};
localparam logic [8:0] SC_START2 = {1'b0, `KEY_START2};
localparam logic [8:0] SC_FIRE_A = {1'b0, `KEY_FIRE_A};
localparam logic [8:0] SC_FIRE_B = {1'b0, `KEY_FIRE_B};
localparam logic [8:0] SC_UP     = {1'b1, `KEY_UP};
localparam logic [8:0] SC_DOWN   = {1'b1, `KEY_DOWN};
localparam logic [8:0] SC_LEFT   = {1'b1, `KEY_LEFT};
localparam logic [8:0] SC_RIGHT  = {1'b1, `KEY_RIGHT};

// bit positions in the held-key vector
localparam int K_COIN   = 0;
localparam int K_START1 = 1;
localparam int K_START2 = 2;
localparam int K_FIRE_A = 3;
localparam int K_FIRE_B = 4;
localparam int K_UP     = 5;
localparam int K_DOWN   = 6;
localparam int K_LEFT   = 7;
localparam int K_RIGHT  = 8;

logic [8:0] held;
logic [8:0] held_nxt;   // includes the event of this cycle
logic       in_up;
logic       in_down;
logic       in_left;
logic       in_right;

always_comb begin
	held_nxt = held;
	if (key_strobe) begin
		case (key_code)
		SC_COIN:   held_nxt[K_COIN]   = key_pressed;
		SC_START1: held_nxt[K_START1] = key_pressed;
		SC_START2: held_nxt[K_START2] = key_pressed;
		SC_FIRE_A: held_nxt[K_FIRE_A] = key_pressed;
		SC_FIRE_B: held_nxt[K_FIRE_B] = key_pressed;
		SC_UP:     held_nxt[K_UP]     = key_pressed;
		SC_DOWN:   held_nxt[K_DOWN]   = key_pressed;
		SC_LEFT:   held_nxt[K_LEFT]   = key_pressed;
		SC_RIGHT:  held_nxt[K_RIGHT]  = key_pressed;
		default: ;                      // unmapped keys ignored
		endcase
	end
end

assign in_up    = held_nxt[K_UP]    | joystick_0.f.up;
assign in_down  = held_nxt[K_DOWN]  | joystick_0.f.down;
assign in_left  = held_nxt[K_LEFT]  | joystick_0.f.left;
assign in_right = held_nxt[K_RIGHT] | joystick_0.f.right;

always_ff @(posedge clk_sys) begin
	if (rst) begin
		held        <= '0;
		key_credit  <= 1'b0;
		btn_coin    <= 1'b0;
		btn_start   <= '0;
		btn_up      <= 1'b0;
		btn_down    <= 1'b0;
		btn_left    <= 1'b0;
		btn_right   <= 1'b0;
		btn_fire    <= 1'b0;
		btn_barrier <= 1'b0;
	end else begin
		held       <= held_nxt;
		key_credit <= key_strobe;       // event consumed, hand the credit back
		btn_coin   <= held_nxt[K_COIN];
		btn_start  <= {held_nxt[K_START2], held_nxt[K_START1]};
		// quarter turn for a sideways cabinet
		btn_up     <= status.f.rotate ? in_right : in_up;
		btn_right  <= status.f.rotate ? in_down  : in_right;
		btn_down   <= status.f.rotate ? in_left  : in_down;
		btn_left   <= status.f.rotate ? in_up    : in_left;
		btn_fire    <= held_nxt[K_FIRE_A] | joystick_0.f.fire_a;
		btn_barrier <= held_nxt[K_FIRE_B] | joystick_0.f.fire_b;
	end
end

endmodule

// ==== hdl/video_scanlines.sv ====
// core syncs are active high and leave inverted; no scan doubler, so dimming is on odd core lines
`timescale 1ns/1ns
`include "arcade_config.svh"

module video_scanlines
	import arcade_cfg_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic [`CORE_COLOR_W-1:0] core_r,
	input  logic [`CORE_COLOR_W-1:0] core_g,
	input  logic [`CORE_COLOR_W-1:0] core_b,
	input  logic                    core_hs,
	input  logic                    core_vs,
	input  logic                    hblank_bg,
	input  logic                    hblank_fg,
	input  logic                    vblank,
	input  status_word_t            status,
	output logic [`VGA_COLOR_W-1:0]  vga_r,
	output logic [`VGA_COLOR_W-1:0]  vga_g,
	output logic [`VGA_COLOR_W-1:0]  vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs
);

localparam int VW  = `VGA_COLOR_W;
localparam int REP = `VGA_COLOR_W / `CORE_COLOR_W;

// optional blend with the previous pixel, then scanline dimming
function automatic logic [VW-1:0] shade(
	input logic [VW-1:0] cur,
	input logic [VW-1:0] prev,
	input logic          mix,
	input logic [1:0]    sl
);
	logic [VW:0]   sum;
	logic [VW-1:0] v;
	sum = {1'b0, cur} + {1'b0, prev};
	v   = mix ? sum[VW:1] : cur;
	case (sl)
	2'd1: v = v - (v >> 2);
	2'd2: v = v - (v >> 1);
	2'd3: v = v - ((v >> 1) + (v >> 2));
	default: ;
	endcase
	return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// stage 1: blanking and colour expansion

logic          blank;
logic [VW-1:0] r1;
logic [VW-1:0] g1;
logic [VW-1:0] b1;
logic [VW-1:0] r0;        // previous stage 1 pixel
logic [VW-1:0] g0;
logic [VW-1:0] b0;
logic          hs1;
logic          vs1;
logic          odd_line;
logic [1:0]    dim_sel;

assign blank   = (hblank_bg & hblank_fg) | vblank;
assign dim_sel = odd_line ? status.f.scanlines : 2'd0;

always_ff @(posedge clk_sys) begin
	r1 <= blank ? '0 : {REP{core_r}};
	g1 <= blank ? '0 : {REP{core_g}};
	b1 <= blank ? '0 : {REP{core_b}};
	r0 <= r1;
	g0 <= g1;
	b0 <= b1;
end

////////////////////////////////////////////////////////////////////////////
// stage 2: blend, dim and output registers

always_ff @(posedge clk_sys) begin
	if (rst) begin
		hs1      <= 1'b1;
		vs1      <= 1'b1;
		odd_line <= 1'b0;
		vga_r    <= '0;
		vga_g    <= '0;
		vga_b    <= '0;
		vga_hs   <= 1'b1;
		vga_vs   <= 1'b1;
	end else begin
		hs1      <= ~core_hs;
		vs1      <= ~core_vs;
		odd_line <= odd_line ^ (core_hs & hs1);   // hs1 high means hs was low
		vga_r    <= shade(r1, r0, status.f.blend, dim_sel);
		vga_g    <= shade(g1, g0, status.f.blend, dim_sel);
		vga_b    <= shade(b1, b0, status.f.blend, dim_sel);
		vga_hs   <= hs1;
		vga_vs   <= vs1;
	end
end

endmodule

// ==== hdl/sigma_delta_dac.sv ====
// first order only, so expect idle tones on quiet input; the output needs an external rc filter
`timescale 1ns/1ns
`include "arcade_config.svh"

module sigma_delta_dac (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic [11:0] audio,
	output logic        audio_out
);

localparam int DW = `DAC_BITS;

logic [DW-1:0] acc;
logic [DW-1:0] sample;
logic [DW:0]   acc_nxt;   // top bit is the carry

assign sample  = {audio, {(DW - 12){1'b0}}};   // sample scaled up to full width
assign acc_nxt = {1'b0, acc} + {1'b0, sample};

always_ff @(posedge clk_sys) begin
	if (rst) begin
		acc       <= '0;
		audio_out <= 1'b0;
	end else begin
		acc       <= acc_nxt[DW-1:0];
		audio_out <= acc_nxt[DW];   // carry density tracks the sample
	end
end

endmodule

// ==== hdl/arcade_shell_top.sv ====
// single clk_sys for everything, no pll, scan doubler or osd; audio_r repeats audio_l
`timescale 1ns/1ns
`include "arcade_config.svh"

module arcade_shell_top
	import arcade_cfg_pkg::*, arcade_input_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    spi_sck,
	input  logic                    spi_di,
	input  logic                    conf_data0,
	input  logic [`CORE_COLOR_W-1:0] core_r,
	input  logic [`CORE_COLOR_W-1:0] core_g,
	input  logic [`CORE_COLOR_W-1:0] core_b,
	input  logic                    core_hs,
	input  logic                    core_vs,
	input  logic                    hblank_bg,
	input  logic                    hblank_fg,
	input  logic                    vblank,
	input  logic [11:0]             audio,
	output logic                    core_reset,
	output logic                    btn_coin,
	output logic [1:0]              btn_start,
	output logic                    btn_left,
	output logic                    btn_right,
	output logic                    btn_up,
	output logic                    btn_down,
	output logic                    btn_fire,
	output logic                    btn_barrier,
	output logic [`VGA_COLOR_W-1:0]  vga_r,
	output logic [`VGA_COLOR_W-1:0]  vga_g,
	output logic [`VGA_COLOR_W-1:0]  vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic                    audio_l,
	output logic                    audio_r
);

status_word_t status;
joy_word_t    joystick_0;
logic         key_strobe;
logic         key_pressed;
logic [8:0]   key_code;
logic         key_credit;   // back from the mapper, one per event

////////////////////////////////////////////////////////////////////////////
// configuration port and controls

user_io_spi spi0 (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.spi_sck     (spi_sck),
	.spi_di      (spi_di),
	.conf_data0  (conf_data0),
	.key_credit  (key_credit),
	.status      (status),
	.buttons     (),            // only button 1 used, inside for core reset
	.switches    (),
	.joystick_0  (joystick_0),
	.key_strobe  (key_strobe),
	.key_pressed (key_pressed),
	.key_code    (key_code),
	.core_reset  (core_reset)
);

arcade_inputs inputs0 (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.key_strobe  (key_strobe),
	.key_pressed (key_pressed),
	.key_code    (key_code),
	.joystick_0  (joystick_0),
	.status      (status),
	.key_credit  (key_credit),
	.btn_coin    (btn_coin),
	.btn_start   (btn_start),
	.btn_left    (btn_left),
	.btn_right   (btn_right),
	.btn_up      (btn_up),
	.btn_down    (btn_down),
	.btn_fire    (btn_fire),
	.btn_barrier (btn_barrier)
);

////////////////////////////////////////////////////////////////////////////
// video and audio paths

video_scanlines video0 (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.core_r    (core_r),
	.core_g    (core_g),
	.core_b    (core_b),
	.core_hs   (core_hs),
	.core_vs   (core_vs),
	.hblank_bg (hblank_bg),
	.hblank_fg (hblank_fg),
	.vblank    (vblank),
	.status    (status),
	.vga_r     (vga_r),
	.vga_g     (vga_g),
	.vga_b     (vga_b),
	.vga_hs    (vga_hs),
	.vga_vs    (vga_vs)
);

sigma_delta_dac dac0 (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.audio     (audio),
	.audio_out (audio_l)
);

assign audio_r = audio_l;   // mono core

endmodule

// ==== testbench/arcade_shell_assertions.sv ====
// bound into user_io_spi and arcade_inputs; a port that does not apply there is tied to 0
`timescale 1ns/1ns

module arcade_shell_assertions (
	input logic clk_sys,
	input logic rst,
	input logic key_strobe,
	input logic key_credit,
	input logic no_credit,   // credit count is zero
	input logic btn_any      // any game control high
);

int unsigned failures = 0;  // polled by the testbench

credit_follows_strobe: assert property (@(posedge clk_sys) disable iff (rst)
	key_credit == $past(key_strobe))
	else begin
		failures++;
		$error("key_credit did not follow key_strobe by one cycle");
	end

strobe_needs_credit: assert property (@(posedge clk_sys) disable iff (rst)
	key_strobe |-> !no_credit)
	else begin
		failures++;
		$error("key_strobe fired with no credit left");
	end

controls_clear_after_rst: assert property (@(posedge clk_sys) $fell(rst) |-> !btn_any)
	else begin
		failures++;
		$error("game controls not clear in the cycle after rst");
	end

endmodule

bind user_io_spi arcade_shell_assertions spi_chk (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.key_strobe (key_strobe),
	.key_credit (key_credit),
	.no_credit  (key_credits == '0),
	.btn_any    (1'b0)
);

bind arcade_inputs arcade_shell_assertions inputs_chk (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.key_strobe (key_strobe),
	.key_credit (key_credit),
	.no_credit  (1'b0),
	.btn_any    (btn_coin | (|btn_start) | btn_up | btn_down | btn_left | btn_right
		| btn_fire | btn_barrier)
);

// ==== testbench/arcade_shell_tb.sv ====
// single player only; sck runs at clk_sys/8 and the bound assertion instances must be present
`timescale 1ns/1ns
`include "arcade_config.svh"

module arcade_shell_tb
	import arcade_cfg_pkg::*, arcade_input_pkg::*;
();

localparam int VW = `VGA_COLOR_W;
localparam int PW = 3 * `VGA_COLOR_W + 2;   // r, g, b, hs, vs

logic                     clk_sys;
logic                     rst = 1'b1;
logic                     spi_sck = 1'b0;
logic                     spi_di = 1'b0;
logic                     conf_data0 = 1'b1;
logic [`CORE_COLOR_W-1:0] core_r = '0;
logic [`CORE_COLOR_W-1:0] core_g = '0;
logic [`CORE_COLOR_W-1:0] core_b = '0;
logic                     core_hs = 1'b0;
logic                     core_vs = 1'b0;
logic                     hblank_bg = 1'b0;
logic                     hblank_fg = 1'b0;
logic                     vblank = 1'b0;
logic [11:0]              audio = '0;
logic                     core_reset;
logic                     btn_coin;
logic [1:0]               btn_start;
logic                     btn_left;
logic                     btn_right;
logic                     btn_up;
logic                     btn_down;
logic                     btn_fire;
logic                     btn_barrier;
logic [VW-1:0]            vga_r;
logic [VW-1:0]            vga_g;
logic [VW-1:0]            vga_b;
logic                     vga_hs;
logic                     vga_vs;
logic                     audio_l;
logic                     audio_r;
logic [8:0]               controls;

logic [31:0]  rng = 32'h39ee_8c6d;
status_word_t cur_status = '0;
joy_word_t    cur_joy = '0;
logic [8:0]   held = '0;        // held-key model, bit i is mapped_key(i)
int           events_sent = 0;
int           credits_seen = 0;
logic         last_hs = 1'b0;   // video model state
logic         line_odd = 1'b0;
logic [VW-1:0] prev_r = '0;
logic [VW-1:0] prev_g = '0;
logic [VW-1:0] prev_b = '0;
logic [PW-1:0] vid_q[$];
logic [PW-1:0] vid_exp;

arcade_shell_top dut0 (.*);

assign controls = {btn_coin, btn_start, btn_up, btn_down, btn_left, btn_right,
	btn_fire, btn_barrier};

initial begin
	clk_sys = 1'b0;
	forever #10 clk_sys = ~clk_sys;
end

////////////////////////////////////////////////////////////////////////////
// random source and reference models

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function logic [31:0] next_word();
	rng = xorshift(rng);
	return rng;
endfunction

function automatic logic [8:0] mapped_key(input int i);
	case (i)
	0: return {1'b0, `KEY_FIRE_B};
	1: return {1'b0, `KEY_FIRE_A};
	2: return {1'b1, `KEY_RIGHT};
	3: return {1'b1, `KEY_LEFT};
	4: return {1'b1, `KEY_DOWN};
	5: return {1'b1, `KEY_UP};
	6: return {1'b0, `KEY_START1};
	7: return {1'b0, `KEY_START2};
	8: return {1'b0, `KEY_COIN};
	default: return 9'h000;
	endcase
endfunction

// {coin, start2, start1, up, down, left, right, fire, barrier}
function automatic logic [8:0] expected_controls(input logic [8:0] keys,
	input joy_word_t joy, input status_word_t st);
	logic u;
	logic d;
	logic l;
	logic r;
	u = keys[5] | joy.f.up;
	d = keys[4] | joy.f.down;
	l = keys[3] | joy.f.left;
	r = keys[2] | joy.f.right;
	if (st.f.rotate) begin
		return {keys[8:6], r, l, u, d, keys[1] | joy.f.fire_a, keys[0] | joy.f.fire_b};
	end
	return {keys[8:6], u, d, l, r, keys[1] | joy.f.fire_a, keys[0] | joy.f.fire_b};
endfunction

function automatic logic [VW-1:0] expand_pixel(input logic [1:0] c, input logic blank);
	return blank ? '0 : {c, c, c};
endfunction

function automatic logic [VW-1:0] shade_ref(input int cur, input int prev,
	input logic blend, input logic [1:0] sl);
	int v;
	v = blend ? (cur + prev) / 2 : cur;
	case (sl)
	2'd1: v = v - v / 4;
	2'd2: v = v - v / 2;
	2'd3: v = v - (v / 2 + v / 4);
	default: ;
	endcase
	return VW'(v);
endfunction

function automatic int expected_ones(input logic [11:0] sample, input int cycles);
	return int'((longint'(cycles) * sample * 8) / (longint'(1) << `DAC_BITS));
endfunction

////////////////////////////////////////////////////////////////////////////
// error handling and compare tasks

task automatic stop_on_error(input string line);
	$display("%s", line);
	$display("TESTBENCH FAILED");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic compare_controls(input logic [8:0] got, input logic [8:0] exp,
	input string what);
	if (got !== exp) begin
		stop_on_error($sformatf("CHECK FAILED at %0t ns: %s controls %b expected %b",
			$time, what, got, exp));
	end
endtask

task automatic compare_pixel(input logic [VW-1:0] r, input logic [VW-1:0] g,
	input logic [VW-1:0] b, input logic hs, input logic vs, input logic [PW-1:0] exp);
	if ({r, g, b, hs, vs} !== exp) begin
		stop_on_error($sformatf("CHECK FAILED at %0t ns: vga %h expected %h",
			$time, {r, g, b, hs, vs}, exp));
	end
endtask

task automatic compare_audio(input int got, input int exp);
	if (got < exp - 1 || got > exp + 1) begin
		stop_on_error($sformatf("CHECK FAILED at %0t ns: %0d ones on audio_l, expected %0d",
			$time, got, exp));
	end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %b expected %b",
			$time, what, got, exp));
	end
endtask

////////////////////////////////////////////////////////////////////////////
// spi driver and stimulus tasks

task automatic tick(input int n);
	repeat (n) @(posedge clk_sys);
endtask

task automatic spi_byte(input logic [7:0] b);
	int i;
	for (i = 7; i >= 0; i--) begin
		spi_di  <= b[i];   // msb first, set while sck low
		spi_sck <= 1'b0;
		tick(4);
		spi_sck <= 1'b1;
		tick(4);
	end
endtask

task automatic spi_write(input logic [7:0] cmd, input logic [31:0] data, input int n);
	int k;
	tick(1);
	conf_data0 <= 1'b0;
	tick(4);
	spi_byte(cmd);
	for (k = 0; k < n; k++) begin
		spi_byte(data[8*k +: 8]);   // low byte first
	end
	spi_sck <= 1'b0;
	tick(4);
	conf_data0 <= 1'b1;
	tick(4);
endtask

task automatic write_status(input status_word_t st);
	spi_write(`CMD_STATUS, st.raw, 4);
	cur_status = st;
endtask

task automatic write_joy(input joy_word_t jw);
	spi_write(`CMD_JOY0, {24'h0, jw.raw}, 1);
	cur_joy = jw;
endtask

task automatic check_controls(input string what);
	@(negedge clk_sys);
	compare_controls(controls, expected_controls(held, cur_joy, cur_status), what);
endtask

task automatic wait_key_events(input int target);
	int waited;
	waited = 0;
	while (credits_seen < target) begin
		@(negedge clk_sys);
		waited++;
		if (waited > 200) begin
			stop_on_error("timeout while waiting for key_credit after a key event");
		end
	end
endtask

task automatic send_key(input logic [8:0] code, input logic pressed);
	int j;
	if (code[8]) begin
		spi_write(`CMD_KEY, {24'h0, `KEY_EXT_PREFIX}, 1);
	end
	if (!pressed) begin
		spi_write(`CMD_KEY, {24'h0, `KEY_REL_PREFIX}, 1);
	end
	spi_write(`CMD_KEY, {24'h0, code[7:0]}, 1);
	events_sent++;
	wait_key_events(events_sent);
	if (credits_seen != events_sent) begin   // prefixes give no event
		stop_on_error($sformatf("CHECK FAILED at %0t ns: %0d key events seen, expected %0d",
			$time, credits_seen, events_sent));
	end
	for (j = 0; j < 9; j++) begin
		if (mapped_key(j) == code) begin
			held[j] = pressed;
		end
	end
	check_controls("key event");
endtask

task automatic drive_pixels(input int n);
	logic [31:0]   w;
	logic          blank;
	logic [1:0]    sl;
	logic [VW-1:0] cr;
	logic [VW-1:0] cg;
	logic [VW-1:0] cb;
	int            i;
	for (i = 0; i < n; i++) begin
		@(posedge clk_sys);
		w = next_word();
		core_r    <= w[1:0];
		core_g    <= w[3:2];
		core_b    <= w[5:4];
		core_hs   <= w[6];
		core_vs   <= w[7];
		hblank_bg <= w[8];
		hblank_fg <= w[9];
		vblank    <= w[10] & w[11];
		blank = (w[8] & w[9]) | (w[10] & w[11]);
		if (w[6] && !last_hs) begin
			line_odd = ~line_odd;   // new line on hs rising
		end
		last_hs = w[6];
		sl = line_odd ? cur_status.f.scanlines : 2'd0;
		cr = expand_pixel(w[1:0], blank);
		cg = expand_pixel(w[3:2], blank);
		cb = expand_pixel(w[5:4], blank);
		vid_q.push_back({shade_ref(cr, prev_r, cur_status.f.blend, sl),
			shade_ref(cg, prev_g, cur_status.f.blend, sl),
			shade_ref(cb, prev_b, cur_status.f.blend, sl), ~w[6], ~w[7]});
		prev_r = cr;
		prev_g = cg;
		prev_b = cb;
	end
endtask

////////////////////////////////////////////////////////////////////////////
// monitors

always @(posedge clk_sys) begin
	if (dut0.key_credit === 1'b1) begin
		credits_seen <= credits_seen + 1;
	end
end

// output of the pixel driven two edges earlier
always @(negedge clk_sys) begin
	if (vid_q.size() > 2) begin
		vid_exp = vid_q.pop_front();
		compare_pixel(vga_r, vga_g, vga_b, vga_hs, vga_vs, vid_exp);
	end
end

always @(negedge clk_sys) begin
	if (dut0.spi0.spi_chk.failures != 0 || dut0.inputs0.inputs_chk.failures != 0) begin
		stop_on_error("a bound assertion on the key credit path or reset state failed");
	end
end

////////////////////////////////////////////////////////////////////////////
// test sequence

initial begin
	status_word_t st;
	joy_word_t    jw;
	logic [31:0]  w;
	int           i;
	int           k;
	int           ones;
	repeat (4) @(posedge clk_sys);
	@(negedge clk_sys);
	compare_bit(core_reset, 1'b1, "core_reset during rst");
	@(posedge clk_sys);
	rst <= 1'b0;
	@(negedge clk_sys);
	compare_controls(controls, 9'h000, "after reset");
	compare_pixel(vga_r, vga_g, vga_b, vga_hs, vga_vs, {{(PW - 2){1'b0}}, 2'b11});
	compare_bit(audio_l, 1'b0, "audio_l after reset");
	tick(2);
	@(negedge clk_sys);
	compare_bit(core_reset, 1'b0, "core_reset after rst");
	st = '0;
	st.f.core_reset = 1'b1;
	write_status(st);
	@(negedge clk_sys);
	compare_bit(core_reset, 1'b1, "core_reset from status");
	st.f.core_reset = 1'b0;
	write_status(st);
	@(negedge clk_sys);
	compare_bit(core_reset, 1'b0, "core_reset cleared by status");

	for (k = 0; k < 2; k++) begin   // rotate off, then on
		st = '0;
		st.f.rotate = k[0];
		write_status(st);
		for (i = 0; i < 8; i++) begin
			w = next_word();
			jw.raw = w[7:0];
			write_joy(jw);
			tick(10);
			check_controls("joystick");
		end
	end

	w = next_word();
	jw.raw = w[7:0] & 8'h15;        // leave some keys visible
	write_joy(jw);
	for (i = 0; i < 9; i++) begin
		send_key(mapped_key(i), 1'b1);
	end
	for (i = 8; i >= 0; i--) begin
		send_key(mapped_key(i), 1'b0);
	end
	send_key(9'h01c, 1'b1);         // unmapped plain key
	send_key(9'h17d, 1'b1);         // unmapped extended key
	send_key(9'h075, 1'b1);         // up byte without the extended prefix
	send_key(9'h114, 1'b1);         // fire A byte with the extended prefix

	for (k = 0; k < 8; k++) begin
		st = '0;
		st.f.scanlines = k[1:0];
		st.f.blend = k[2];
		write_status(st);
		vid_q.delete();
		drive_pixels(200);
	end

	for (k = 0; k < 4; k++) begin
		w = next_word();
		@(posedge clk_sys);
		audio <= w[11:0];
		@(posedge clk_sys);
		ones = 0;
		for (i = 0; i < 4096; i++) begin
			@(negedge clk_sys);
			compare_bit(audio_r, audio_l, "audio_r against audio_l");
			ones = ones + int'(audio_l);
		end
		compare_audio(ones, expected_ones(w[11:0], 4096));
	end

	$display("TESTBENCH PASSED");
	$finish;
end

endmodule

// ==== build.f ====
+incdir+include
hdl/arcade_cfg_pkg.sv
hdl/arcade_input_pkg.sv
hdl/user_io_spi.sv
hdl/arcade_inputs.sv
hdl/video_scanlines.sv
hdl/sigma_delta_dac.sv
hdl/arcade_shell_top.sv
testbench/arcade_shell_assertions.sv
testbench/arcade_shell_tb.sv

// ==== Bender.yml ====
package:
  name: arcade_shell

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/arcade_cfg_pkg.sv
      - hdl/arcade_input_pkg.sv
      - hdl/user_io_spi.sv
      - hdl/arcade_inputs.sv
      - hdl/video_scanlines.sv
      - hdl/sigma_delta_dac.sv
      - hdl/arcade_shell_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/arcade_shell_assertions.sv
      - testbench/arcade_shell_tb.sv
